// ==== verilog/archPkg.sv ====
package archPkg;

    localparam int dataWidth = 8;
    localparam int regCount  = 4;
    localparam int progDepth = 16;   // Program words
    localparam int dataDepth = 16;   // Data words

    typedef logic [$clog2(regCount)-1:0]  regAddr_t;
    typedef logic [$clog2(progDepth)-1:0] pcAddr_t;
    typedef logic [$clog2(dataDepth)-1:0] memAddr_t;   // Low bits of a register
    typedef logic [dataWidth-1:0]         data_t;

    // One instruction takes all three phases in order
    typedef enum logic [1:0] {
        phaseFetch   = 2'd0,
        phaseDecode  = 2'd1,
        phaseExecute = 2'd2
    } phase_t;

    // Writeback source
    typedef enum logic {
        wbAlu = 1'b0,
        wbMem = 1'b1
    } wbSel_t;

endpackage

// ==== verilog/isaPkg.sv ====
package isaPkg;

    // Full opcodes, memory and control classes ignore bit 4
    typedef enum logic [3:0] {
        opAdd   = 4'b0000,
        opSub   = 4'b0001,
        opAnd   = 4'b0010,
        opOr    = 4'b0011,
        opXor   = 4'b0100,
        opMov   = 4'b0101,
        opAddi  = 4'b0110,
        opNop   = 4'b0111,
        opStore = 4'b1000,
        opLoad  = 4'b1010,
        opCmp   = 4'b1100,
        opJmp   = 4'b1110
    } opcode_t;

    // Top three bits of memory and control words
    typedef enum logic [2:0] {
        clsStore = 3'b100,
        clsLoad  = 3'b101,
        clsCmp   = 3'b110,
        clsJmp   = 3'b111
    } instrClass_t;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluPassB,
        aluCompare
    } aluOp_t;

    // Unsigned compare of r0 against r1, unlisted codes clear the flag
    typedef enum logic [3:0] {
        condNever = 4'd0,
        condEq    = 4'd1,
        condNe    = 4'd2,
        condLtu   = 4'd3,
        condGtu   = 4'd4,
        condLeu   = 4'd5,
        condGeu   = 4'd6
    } cond_t;

    typedef struct packed {
        opcode_t           opcode;
        archPkg::regAddr_t ra;
        archPkg::regAddr_t rb;       // Also the ADDI immediate
    } aluForm_t;

    typedef struct packed {
        instrClass_t       cls;
        archPkg::regAddr_t ra;       // Data register
        archPkg::regAddr_t rb;       // Address register
        logic              spare;
    } memForm_t;

    typedef struct packed {
        instrClass_t cls;
        logic [3:0]  field;          // Condition for CMP, target for JMP
        logic        isCond;
    } ctlForm_t;

    typedef union packed {
        aluForm_t aluForm;
        memForm_t memForm;
        ctlForm_t ctlForm;
    } instr_t;

endpackage

// ==== verilog/ctrlIf.sv ====
`timescale 1ns/1ps

interface ctrlIf import archPkg::*, isaPkg::*; ();

    logic     regWe;        // Execute only
    regAddr_t wbReg;
    wbSel_t   wbSel;
    logic     useImm;       // ALU b from the immediate
    aluOp_t   aluOp;
    logic     memWe;        // Execute only
    logic     flagWe;       // Execute only
    logic     jump;         // Execute only
    logic     jumpIfFlag;
    pcAddr_t  target;

    modport decoder (
        output regWe, wbReg, wbSel, useImm, aluOp,
        output memWe, flagWe, jump, jumpIfFlag, target
    );

    modport datapath (
        input regWe, wbReg, wbSel, useImm, aluOp,
        input memWe, flagWe, jump, jumpIfFlag, target
    );

endinterface

// ==== verilog/fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit import archPkg::*, isaPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    run,
    input  logic    progWe,
    input  pcAddr_t progAddr,
    input  data_t   progData,
    input  logic    flag,
    ctrlIf.datapath ctl,
    output instr_t  instr,
    output phase_t  phase,
    output pcAddr_t pc
);

    data_t progMem [progDepth];
    logic  jumpTaken;

    // Unconditional, or conditional with the flag set
    assign jumpTaken = ctl.jump && (!ctl.jumpIfFlag || flag);

    ////////////////////////////////////////////////////////////////////////////
    // Program memory
    ////////////////////////////////////////////////////////////////////////////

    // Loaded only while the core idles in fetch
    always_ff @(posedge clk) begin
        if (progWe && !run && phase == phaseFetch) begin
            progMem[progAddr] <= progData;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Phase counter, pc and instruction register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            phase                <= phaseFetch;
            pc                   <= '0;
            instr.aluForm.opcode <= opNop;
            instr.aluForm.ra     <= '0;
            instr.aluForm.rb     <= '0;
        end else begin
            case (phase)
                phaseFetch: begin
                    if (run) begin              // Holds here once stopped
                        instr <= progMem[pc];
                        phase <= phaseDecode;
                    end
                end
                phaseDecode: begin
                    phase <= phaseExecute;
                end
                phaseExecute: begin
                    phase <= phaseFetch;
                    if (jumpTaken) begin
                        pc <= ctl.target;
                    end else begin
                        pc <= pc + 1'b1;        // Wraps at 16
                    end
                end
                default: begin
                    phase <= phaseFetch;
                end
            endcase
        end
    end

endmodule

// ==== verilog/controlDecoder.sv ====
`timescale 1ns/1ps

module controlDecoder import archPkg::*, isaPkg::*; (
    input  instr_t  instr,
    input  phase_t  phase,
    ctrlIf.decoder  ctl
);

    logic execute;

    // Every write and the jump happen in execute only
    assign execute = (phase == phaseExecute);

    always_comb begin
        // Defaults leave a NOP with no effect
        ctl.regWe      = 1'b0;
        ctl.wbReg      = instr.aluForm.ra;
        ctl.wbSel      = wbAlu;
        ctl.useImm     = 1'b0;
        ctl.aluOp      = aluAdd;
        ctl.memWe      = 1'b0;
        ctl.flagWe     = 1'b0;
        ctl.jump       = 1'b0;
        ctl.jumpIfFlag = 1'b0;
        ctl.target     = instr.ctlForm.field;

        if (!instr.aluForm.opcode[3]) begin
            // Register forms, ra is also the destination
            ctl.regWe = execute && (instr.aluForm.opcode != opNop);
            case (instr.aluForm.opcode)
                opAdd:   ctl.aluOp = aluAdd;
                opSub:   ctl.aluOp = aluSub;
                opAnd:   ctl.aluOp = aluAnd;
                opOr:    ctl.aluOp = aluOr;
                opXor:   ctl.aluOp = aluXor;
                opMov:   ctl.aluOp = aluPassB;
                opAddi: begin
                    ctl.aluOp  = aluAdd;
                    ctl.useImm = 1'b1;
                end
                default: ctl.aluOp = aluAdd;   // NOP
            endcase
        end else begin
            case (instr.ctlForm.cls)
                clsStore: begin
                    ctl.memWe = execute;
                end
                clsLoad: begin
                    ctl.regWe = execute;
                    ctl.wbSel = wbMem;
                    ctl.wbReg = instr.memForm.ra;
                end
                clsCmp: begin
                    ctl.flagWe = execute;
                    ctl.aluOp  = aluCompare;
                end
                clsJmp: begin
                    ctl.jump       = execute;
                    ctl.jumpIfFlag = instr.ctlForm.isCond;
                end
                default: begin
                    ctl.jump = 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== verilog/registerFile.sv ====
`timescale 1ns/1ps

module registerFile import archPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  regAddr_t raddrA,
    input  regAddr_t raddrB,
    output data_t    rdataA,
    output data_t    rdataB,
    input  logic     we,
    input  regAddr_t waddr,
    input  data_t    wdata
);

    data_t regs [regCount];

    // Two read ports, both combinational
    assign rdataA = regs[raddrA];
    assign rdataB = regs[raddrB];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            regs <= '{default: '0};
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu import archPkg::*, isaPkg::*; (
    input  data_t  a,
    input  data_t  b,
    input  aluOp_t op,
    input  cond_t  cond,
    output data_t  result,
    output logic   condTrue
);

    // Results wrap at 256
    always_comb begin
        case (op)
            aluAdd:             result = a + b;
            aluSub, aluCompare: result = a - b;
            aluAnd:             result = a & b;
            aluOr:              result = a | b;
            aluXor:             result = a ^ b;
            aluPassB:           result = b;      // MOV
            default:            result = a + b;
        endcase
    end

    // Unsigned, a is r0 and b is r1 for CMP
    always_comb begin
        case (cond)
            condNever: condTrue = 1'b0;
            condEq:    condTrue = (a == b);
            condNe:    condTrue = (a != b);
            condLtu:   condTrue = (a < b);
            condGtu:   condTrue = (a > b);
            condLeu:   condTrue = (a <= b);
            condGeu:   condTrue = (a >= b);
            default:   condTrue = 1'b0;
        endcase
    end

endmodule

// ==== verilog/dataMemory.sv ====
`timescale 1ns/1ps

module dataMemory import archPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     we,
    input  memAddr_t addr,
    input  data_t    wdata,
    output data_t    rdata
);

    data_t mem [dataDepth];

    assign rdata = mem[addr];   // Same-cycle read for LOAD

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mem <= '{default: '0};
        end else if (we) begin
            mem[addr] <= wdata;
        end
    end

endmodule

// ==== verilog/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop import archPkg::*, isaPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     run,
    input  logic     progWe,
    input  pcAddr_t  progAddr,
    input  data_t    progData,
    output logic     retireValid,
    output pcAddr_t  retirePc,
    output logic     regWe,
    output regAddr_t regAddr,
    output data_t    regData,
    output logic     memWe,
    output memAddr_t memAddr,
    output data_t    memData
);

    instr_t   instr;
    phase_t   phase;
    pcAddr_t  pc;
    regAddr_t raddrA;
    regAddr_t raddrB;
    data_t    rdataA;
    data_t    rdataB;
    data_t    aluB;
    data_t    aluResult;
    data_t    memRdata;
    logic     condTrue;
    logic     flag;

    ctrlIf ctl ();

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////

    fetchUnit i_fetchUnit (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .flag     (flag),
        .ctl      (ctl.datapath),
        .instr    (instr),
        .phase    (phase),
        .pc       (pc)
    );

    controlDecoder i_controlDecoder (
        .instr (instr),
        .phase (phase),
        .ctl   (ctl.decoder)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////

    // Operand registers depend on the form
    always_comb begin
        if (instr.ctlForm.cls == clsCmp) begin
            raddrA = 2'd0;                  // CMP always looks at r0 and r1
            raddrB = 2'd1;
        end else if (instr.aluForm.opcode[3]) begin
            raddrA = instr.memForm.ra;
            raddrB = instr.memForm.rb;
        end else begin
            raddrA = instr.aluForm.ra;
            raddrB = instr.aluForm.rb;
        end
    end

    assign aluB = ctl.useImm ? data_t'(instr.aluForm.rb) : rdataB;   // Zero-extended imm

    registerFile i_registerFile (
        .clk    (clk),
        .rst    (rst),
        .raddrA (raddrA),
        .raddrB (raddrB),
        .rdataA (rdataA),
        .rdataB (rdataB),
        .we     (ctl.regWe),
        .waddr  (ctl.wbReg),
        .wdata  (regData)
    );

    alu i_alu (
        .a        (rdataA),
        .b        (aluB),
        .op       (ctl.aluOp),
        .cond     (cond_t'(instr.ctlForm.field)),
        .result   (aluResult),
        .condTrue (condTrue)
    );

    dataMemory i_dataMemory (
        .clk   (clk),
        .rst   (rst),
        .we    (ctl.memWe),
        .addr  (memAddr),
        .wdata (memData),
        .rdata (memRdata)
    );

    // Compare flag, read by conditional jumps
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            flag <= 1'b0;
        end else if (ctl.flagWe) begin
            flag <= condTrue;
        end
    end

    // Observation
    assign retireValid = (phase == phaseExecute);
    assign retirePc    = pc;
    assign regWe       = ctl.regWe;
    assign regAddr     = ctl.wbReg;
    assign regData     = (ctl.wbSel == wbMem) ? memRdata : aluResult;
    assign memWe       = ctl.memWe;
    assign memAddr     = rdataB[$bits(memAddr_t)-1:0];
    assign memData     = rdataA;

endmodule

// ==== bench/cpuTop_props.sv ====
`timescale 1ns/1ps

module cpuTopProps (
    input logic clk,
    input logic rst,
    input logic run,
    input logic retireValid,
    input logic regWe,
    input logic memWe
);

    int failCount;      // Failed assertions so far

    // Fetch and decode come first after reset
    assert property (@(posedge clk) $rose(rst) |-> !retireValid ##1 !retireValid)
        else begin
            $error("retireValid high right after reset");
            failCount++;
        end

    assert property (@(posedge clk) disable iff (!rst) (regWe || memWe) |-> retireValid)
        else begin
            $error("write enable outside a retire");
            failCount++;
        end

    // One instruction every 3 cycles once fetched with run high
    assert property (@(posedge clk) disable iff (!rst)
        retireValid ##1 run |-> !retireValid ##1 !retireValid ##1 retireValid)
        else begin
            $error("retire pulses not 3 cycles apart");
            failCount++;
        end

endmodule

bind cpuTop cpuTopProps i_cpuTopProps (
    .clk         (clk),
    .rst         (rst),
    .run         (run),
    .retireValid (retireValid),
    .regWe       (regWe),
    .memWe       (memWe)
);

// ==== bench/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb import archPkg::*, isaPkg::*; ();

    localparam int clkPeriod    = 4;
    localparam int maxTests     = 20;
    localparam int testOverhead = 40;   // Cycles to load, reset and stop one test

    logic     clk;
    logic     rst;
    logic     run;
    logic     progWe;
    pcAddr_t  progAddr;
    data_t    progData;
    logic     retireValid;
    pcAddr_t  retirePc;
    logic     regWe;
    regAddr_t regAddr;
    data_t    regData;
    logic     memWe;
    memAddr_t memAddr;
    data_t    memData;

    string  testName  [maxTests];
    data_t  testProg  [maxTests][progDepth];
    int     testCount [maxTests];   // Instructions to retire
    int     numTests;
    int     cycleLimit;
    bit     tableReady;
    integer seed;
    string  curName;

    // Golden ISA model and the retire it expects
    data_t    modelReg [regCount];
    data_t    modelMem [dataDepth];
    logic     modelFlag;
    pcAddr_t  modelPc;
    pcAddr_t  expPc;
    logic     expRegWe;
    regAddr_t expRegAddr;
    data_t    expRegData;
    logic     expMemWe;
    memAddr_t expMemAddr;
    data_t    expMemData;

    cpuTop i_cpuTop (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "Run stopped at %0t ns", $time);
    endtask

    function automatic string mismatchText(input string what, input logic [7:0] exp,
                                           input logic [7:0] act);
        return $sformatf("mismatch in %s, %s: expected %0h, actual %0h",
                         curName, what, exp, act);
    endfunction

    task automatic checkData(input string what, input data_t exp, input data_t act);
        if (exp !== act) failRun(mismatchText(what, exp, act));
    endtask

    task automatic checkPc(input string what, input pcAddr_t exp, input pcAddr_t act);
        if (exp !== act) failRun(mismatchText(what, exp, act));
    endtask

    task automatic checkReg(input string what, input regAddr_t exp, input regAddr_t act);
        if (exp !== act) failRun(mismatchText(what, exp, act));
    endtask

    task automatic checkAddr(input string what, input memAddr_t exp, input memAddr_t act);
        if (exp !== act) failRun(mismatchText(what, exp, act));
    endtask

    task automatic checkBit(input string what, input logic exp, input logic act);
        if (exp !== act) failRun(mismatchText(what, exp, act));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Golden model
    ////////////////////////////////////////////////////////////////////////////

    // Unsigned compare of x as r0 with y as r1
    function automatic logic condHolds(input logic [3:0] code, input data_t x, input data_t y);
        case (code)
            4'd1:    return x == y;
            4'd2:    return x != y;
            4'd3:    return x < y;
            4'd4:    return x > y;
            4'd5:    return x <= y;
            4'd6:    return x >= y;
            default: return 1'b0;       // Never and the unused codes
        endcase
    endfunction

    task automatic stepModel(input data_t word);
        regAddr_t ra;
        regAddr_t rb;
        data_t    a;
        data_t    b;
        logic     taken;
        taken      = 1'b0;
        expPc      = modelPc;
        expRegWe   = 1'b0;
        expMemWe   = 1'b0;
        expRegAddr = '0;
        expRegData = '0;
        expMemAddr = '0;
        expMemData = '0;
        if (!word[7]) begin
            ra         = word[3:2];
            rb         = word[1:0];
            a          = modelReg[ra];
            b          = modelReg[rb];
            expRegWe   = (word[7:4] != 4'b0111);    // All but NOP write ra
            expRegAddr = ra;
            case (word[6:4])
                3'd0:    expRegData = a + b;
                3'd1:    expRegData = a - b;
                3'd2:    expRegData = a & b;
                3'd3:    expRegData = a | b;
                3'd4:    expRegData = a ^ b;
                3'd5:    expRegData = b;
                3'd6:    expRegData = a + {6'd0, rb};
                default: expRegData = a;
            endcase
            if (expRegWe) modelReg[ra] = expRegData;
        end else begin
            ra = word[4:3];
            rb = word[2:1];
            a  = modelReg[ra];
            b  = modelReg[rb];
            case (word[6:5])
                2'b00: begin                        // STORE
                    expMemWe             = 1'b1;
                    expMemAddr           = b[3:0];
                    expMemData           = a;
                    modelMem[expMemAddr] = a;
                end
                2'b01: begin                        // LOAD
                    expRegWe     = 1'b1;
                    expRegAddr   = ra;
                    expRegData   = modelMem[b[3:0]];
                    modelReg[ra] = expRegData;
                end
                2'b10:   modelFlag = condHolds(word[4:1], modelReg[0], modelReg[1]);
                default: taken = !word[0] || modelFlag;
            endcase
        end
        modelPc = taken ? word[4:1] : modelPc + 1'b1;
    endtask

    task automatic checkRetire(input int t);
        stepModel(testProg[t][modelPc]);
        checkPc("retirePc", expPc, retirePc);
        checkBit("regWe", expRegWe, regWe);
        checkBit("memWe", expMemWe, memWe);
        if (expRegWe) begin
            checkReg("regAddr", expRegAddr, regAddr);
            checkData("regData", expRegData, regData);
        end
        if (expMemWe) begin
            checkAddr("memAddr", expMemAddr, memAddr);
            checkData("memData", expMemData, memData);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test table
    ////////////////////////////////////////////////////////////////////////////

    task automatic addTest(input string name, input int count);
        testName[numTests]  = name;
        testCount[numTests] = count;
        numTests++;
    endtask

    task automatic buildTable();
        logic [3:0] code;
        logic [3:0] tgt;
        int         base;
        data_t      r;
        // r0 doubles until it wraps, then every register op
        testProg[numTests] = '{8'h63, 8'h66, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
                               8'h00, 8'h14, 8'h59, 8'h28, 8'h3D, 8'h4E, 8'h6F, 8'h70};
        addTest("aluOps", 16);
        testProg[numTests] = '{8'h67, 8'h6A, 8'h63, 8'h00, 8'h82, 8'h90, 8'hBA, 8'hA8,
                               8'hB4, 8'h9A, 8'hA2, 8'h70, 8'h70, 8'h70, 8'h70, 8'h70};
        addTest("storeLoad", 12);
        testProg[numTests] = '{8'h61, 8'hFA, 8'h6F, 8'h6F, 8'h6F, 8'h6F, 8'h6F, 8'h6F,
                               8'h6F, 8'h6F, 8'h6F, 8'h6F, 8'h6F, 8'h65, 8'h70, 8'h69};
        addTest("jumpWrap", 20);
        testProg[numTests] = '{8'h70, 8'h61, 8'hE7, 8'h70, 8'h70, 8'h70, 8'h70, 8'h70,
                               8'h70, 8'h70, 8'h70, 8'h70, 8'h70, 8'h70, 8'h70, 8'h70};
        addTest("nopStop", 5);
        // Four codes per program with r0 below, equal to and above r1
        for (int rel = 0; rel < 3; rel++) begin
            for (int g = 0; g < 4; g++) begin
                testProg[numTests][0] = {4'b0110, 2'd0, 2'(rel + 1)};
                testProg[numTests][1] = {4'b0110, 2'd1, (rel == 2) ? 2'd1 : 2'd2};
                for (int k = 0; k < 4; k++) begin
                    base = 2 + 3 * k;
                    code = 4'(4 * g + k);
                    tgt  = 4'(base + 3);
                    testProg[numTests][base]     = {3'b110, code, 1'b0};
                    testProg[numTests][base + 1] = {3'b111, tgt, 1'b1};
                    testProg[numTests][base + 2] = 8'h69;     // Skipped when taken
                end
                testProg[numTests][14] = 8'hE0;
                testProg[numTests][15] = 8'h70;
                addTest($sformatf("cmp%0d codes %0d-%0d", rel, 4 * g, 4 * g + 3), 16);
            end
        end
        for (int n = 0; n < 2; n++) begin
            for (int i = 0; i < progDepth; i++) begin
                r = data_t'($random(seed));
                testProg[numTests][i] = (i < 6) ? {4'b0110, r[3:0]} : r;   // ADDI chain first
            end
            addTest($sformatf("random%0d", n), 40);
        end
    endtask

    task automatic runTest(input int t);
        int n;
        n       = testCount[t];
        curName = testName[t];
        run     = 1'b0;
        repeat (3) @(negedge clk);
        for (int i = 0; i < progDepth; i++) begin
            progWe   = 1'b1;
            progAddr = pcAddr_t'(i);
            progData = testProg[t][i];
            @(negedge clk);
        end
        progWe = 1'b0;
        rst    = 1'b0;
        repeat (5) @(negedge clk);
        rst       = 1'b1;
        modelReg  = '{default: '0};
        modelMem  = '{default: '0};
        modelFlag = 1'b0;
        modelPc   = '0;
        @(negedge clk);
        run = 1'b1;
        for (int i = 0; i < n; i++) begin
            if (i == n - 1) begin
                // Run drops in decode of the last one
                repeat ((i == 0) ? 1 : 2) begin
                    @(negedge clk);
                    if (retireValid) failRun("an instruction retired earlier than 3 cycles");
                end
                run = 1'b0;
            end
            @(negedge clk);
            while (!retireValid) @(negedge clk);
            checkRetire(t);
        end
        repeat (9) begin
            @(negedge clk);
            if (retireValid) failRun({curName, ": the core kept retiring after run went low"});
        end
    endtask

    initial begin
        rst        = 1'b0;
        run        = 1'b0;
        progWe     = 1'b0;
        progAddr   = '0;
        progData   = '0;
        seed       = 32'hf94c_67e6;
        numTests   = 0;
        tableReady = 1'b0;
        buildTable();
        cycleLimit = 5 + 200;
        for (int t = 0; t < numTests; t++) begin
            cycleLimit += testOverhead + 3 * testCount[t];
        end
        tableReady = 1'b1;
        repeat (5) @(negedge clk);
        rst = 1'b1;
        for (int t = 0; t < numTests; t++) begin
            runTest(t);
        end
        if (i_cpuTop.i_cpuTopProps.failCount == 0) begin
            $display("No errors");
            $finish;
        end else begin
            failRun("a timing assertion on the DUT failed");
        end
    end

    // A failed bound assertion ends the run at once
    initial begin
        @(i_cpuTop.i_cpuTopProps.failCount);
        failRun("a timing assertion on the DUT failed");
    end

    // Watchdog
    initial begin
        wait (tableReady);
        repeat (cycleLimit) @(posedge clk);
        failRun($sformatf("the processor stopped retiring, no end after %0d cycles", cycleLimit));
    end

endmodule

// ==== files.f ====
verilog/archPkg.sv
verilog/isaPkg.sv
verilog/ctrlIf.sv
verilog/fetchUnit.sv
verilog/controlDecoder.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/dataMemory.sv
verilog/cpuTop.sv
bench/cpuTop_props.sv
bench/cpuTb.sv

// ==== Bender.yml ====
package:
  name: mini_cpu

sources:
  - verilog/archPkg.sv
  - verilog/isaPkg.sv
  - verilog/ctrlIf.sv
  - verilog/fetchUnit.sv
  - verilog/controlDecoder.sv
  - verilog/registerFile.sv
  - verilog/alu.sv
  - verilog/dataMemory.sv
  - verilog/cpuTop.sv
  - target: simulation
    files:
      - bench/cpuTop_props.sv
      - bench/cpuTb.sv
